// File: sim/game_tests.txt
// One round per line: tap count (hex) and false-start flag (1 = one tap during QUESTION)
// Two matches of four rounds each
3 0
0 1
a 0
5 0
0 0
9 0
0 1
7 0

// File: sources.f
+incdir+rtl
rtl/gamePkg.sv
rtl/segPkg.sv
rtl/btnSync.sv
rtl/questionGen.sv
rtl/gameCtrl.sv
rtl/segDecoder.sv
rtl/gameTop.sv
sim/gameTb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP      := gameTb
FILELIST := sources.f
BUILDDIR := obj_dir
BIN      := $(BUILDDIR)/V$(TOP)
LOG      := sim.log
PASSMSG  := All tests passed!

SOURCES  := $(shell grep -v '^+' $(FILELIST)) rtl/game_macros.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o V$(TOP)

run: $(BIN) sim/game_tests.txt
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASSMSG)" $(LOG) && echo "Simulation PASS" || (echo "Simulation FAIL"; exit 1)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: sim/gameTb.sv
`include "game_macros.svh"

module gameTb import gamePkg::*, segPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int Matches     = 2;
    localparam int Rounds      = Matches * `ROUND_COUNT;
    localparam int PressCycles = 24;                    // 12 high plus 12 low
    localparam int RoundCycles = `QUESTION_CYCLES + `INPUT_CYCLES + `RESULT_CYCLES;

    logic       CLK;
    logic       rstN;
    logic       startBtn;
    logic       tapBtn;
    logic [6:0] nHex;
    logic [3:0] gameState;

    logic [3:0] testWords [0:2*Rounds-1];               // Tap count and false-start flag
    int         watchdogCycles;
    bit         limitKnown;

    gameTop UUT (
        .CLK       (CLK),
        .rstN      (rstN),
        .startBtn  (startBtn),
        .tapBtn    (tapBtn),
        .nHex      (nHex),
        .gameState (gameState)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;                              // 100 ns period

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic checkState(input gameState_t expected);
        gameState_t actual;
        actual = gameState_t'(gameState);
        if (actual !== expected) begin
            stopRun($sformatf("CHECK FAILED at %0t ns: gameState expected %s (%b), got %s (%b)",
                $time, expected.name(), expected, actual.name(), gameState));
        end
    endtask

    task automatic checkSeg(input seg_t expected);
        if (nHex !== expected) begin
            stopRun($sformatf("CHECK FAILED at %0t ns: nHex expected %b, got %b",
                $time, expected, nHex));
        end
    endtask

    // Glyph back to digit or -1 for a non-digit glyph
    function automatic int decodeDigit(input seg_t glyph);
        case (glyph)
            SEG_DIGIT0: return 0;
            SEG_DIGIT1: return 1;
            SEG_DIGIT2: return 2;
            SEG_DIGIT3: return 3;
            SEG_DIGIT4: return 4;
            SEG_DIGIT5: return 5;
            SEG_DIGIT6: return 6;
            SEG_DIGIT7: return 7;
            SEG_DIGIT8: return 8;
            SEG_DIGIT9: return 9;
            default:    return -1;
        endcase
    endfunction

    function automatic seg_t barGlyph(input int taps);
        if (taps <= 4) return SEG_DASH;
        if (taps <= 8) return SEG_DIGIT1;
        if (taps == 9) return SEG_DIGIT2;
        return SEG_BLANK;                               // Overshoot
    endfunction

    task automatic idleGap();
        int n;
        n = $urandom % 11;                              // 0 to 10 cycles
        repeat (n) @(posedge CLK);
    endtask

    task automatic pressButton(input bit isTap);
        @(posedge CLK);
        if (isTap) tapBtn <= 1'b1;
        else       startBtn <= 1'b1;
        repeat (PressCycles / 2) @(posedge CLK);
        tapBtn   <= 1'b0;
        startBtn <= 1'b0;
        repeat (PressCycles / 2) @(posedge CLK);      // Released long enough to settle
    endtask

    task automatic waitForState(input gameState_t s);
        @(negedge CLK);
        while (gameState_t'(gameState) != s) begin
            @(negedge CLK);
        end
    endtask

    task automatic waitWhileState(input gameState_t s);
        @(negedge CLK);
        while (gameState_t'(gameState) == s) begin
            @(negedge CLK);
        end
    endtask

    initial begin
        int         taps;
        bit         falseStart;
        int         digit;
        int         goods;
        int         fails;
        int         pressTotal;
        int         idx;
        gameState_t result;
        seg_t       resultGlyph;

        rstN       = 1'b0;
        startBtn   = 1'b0;
        tapBtn     = 1'b0;
        limitKnown = 1'b0;
        void'($urandom(32'h5be));
        $readmemh("sim/game_tests.txt", testWords);

        pressTotal = 2 * Matches;                       // Start and restart per match
        for (int i = 0; i < Rounds; i++) begin
            if ($isunknown(testWords[2*i]) || $isunknown(testWords[2*i+1]) ||
                testWords[2*i+1] > 4'd1) begin
                stopRun($sformatf("Data file entry for round %0d is missing or malformed", i));
            end
            pressTotal += testWords[2*i] + 1;
        end
        // Twice the windows plus presses with their worst gaps
        watchdogCycles = 2 * (Rounds * RoundCycles + pressTotal * (PressCycles + 12) + 10);
        limitKnown = 1'b1;

        repeat (4) @(posedge CLK);
        rstN <= 1'b1;
        @(posedge CLK);                                 // IDLE to READY
        @(negedge CLK);
        checkState(READY);
        checkSeg(SEG_E);

        for (int m = 0; m < Matches; m++) begin
            goods = 0;
            fails = 0;
            idleGap();
            pressButton(1'b0);
            for (int r = 0; r < `ROUND_COUNT; r++) begin
                idx        = 2 * (m * `ROUND_COUNT + r);
                taps       = testWords[idx];
                falseStart = testWords[idx+1][0];
                waitForState(QUESTION);
                digit = decodeDigit(nHex);
                if (digit < 0) begin
                    stopRun($sformatf("QUESTION shows %b, which is not a digit glyph", nHex));
                end
                if (falseStart) begin
                    idleGap();
                    pressButton(1'b1);                  // Early tap
                    @(negedge CLK);
                    result      = OUCH;
                    resultGlyph = SEG_O;
                    fails++;
                end else begin
                    waitForState(INPUT);
                    checkSeg(barGlyph(0));
                    for (int t = 1; t <= taps; t++) begin
                        idleGap();
                        pressButton(1'b1);
                        @(negedge CLK);
                        checkState(INPUT);
                        checkSeg(barGlyph(t));
                    end
                    waitWhileState(INPUT);
                    if (taps == digit) begin
                        result      = GOOD;
                        resultGlyph = SEG_G;
                        goods++;
                    end else begin
                        result      = WRONG;
                        resultGlyph = SEG_F;
                        fails++;
                    end
                end
                checkState(result);
                checkSeg(resultGlyph);
                waitWhileState(result);
            end

            // Verdict from own tally
            if (goods > fails) begin
                result      = WIN;
                resultGlyph = SEG_B;
            end else if (goods < fails) begin
                result      = LOSE;
                resultGlyph = SEG_L;
            end else begin
                result      = DRAW;
                resultGlyph = SEG_BLANK;
            end
            checkState(result);
            checkSeg(resultGlyph);

            idleGap();
            pressButton(1'b0);                          // Back to READY
            @(negedge CLK);
            checkState(READY);
            checkSeg(SEG_E);
        end

        $display("All tests passed!");
        $finish;
    end

    initial begin
        wait (limitKnown);
        repeat (watchdogCycles) @(posedge CLK);
        stopRun($sformatf("Timeout: the game did not finish both matches within %0d cycles",
            watchdogCycles));
    end

endmodule

// File: rtl/gameTop.sv
module gameTop import gamePkg::*; (
    input  logic       CLK,
    input  logic       rstN,
    input  logic       startBtn,
    input  logic       tapBtn,
    output logic [6:0] nHex,
    output logic [3:0] gameState        // LED view of the state
);

    logic       startPress;
    logic       tapPress;
    digit_t     digit;
    gameState_t state;
    digit_t     question;
    digit_t     tapCount;

    assign gameState = state;

    btnSync startSync (
        .CLK   (CLK),
        .rstN  (rstN),
        .raw   (startBtn),
        .press (startPress)
    );

    btnSync tapSync (
        .CLK   (CLK),
        .rstN  (rstN),
        .raw   (tapBtn),
        .press (tapPress)
    );

    questionGen questionGen (
        .CLK   (CLK),
        .rstN  (rstN),
        .digit (digit)
    );

    gameCtrl gameCtrl (
        .CLK        (CLK),
        .rstN       (rstN),
        .startPress (startPress),
        .tapPress   (tapPress),
        .nextDigit  (digit),
        .state      (state),
        .question   (question),
        .tapCount   (tapCount)
    );

    segDecoder segDecoder (
        .state    (state),
        .question (question),
        .tapCount (tapCount),
        .nHex     (nHex)
    );

endmodule

// File: rtl/segDecoder.sv
module segDecoder import gamePkg::*, segPkg::*; (
    input  gameState_t state,
    input  digit_t     question,
    input  digit_t     tapCount,
    output seg_t       nHex             // Active low segments
);

    always_comb begin
        case (state)
            READY:    nHex = SEG_E;
            QUESTION: begin
                case (question)
                    4'd0:    nHex = SEG_DIGIT0;
                    4'd1:    nHex = SEG_DIGIT1;
                    4'd2:    nHex = SEG_DIGIT2;
                    4'd3:    nHex = SEG_DIGIT3;
                    4'd4:    nHex = SEG_DIGIT4;
                    4'd5:    nHex = SEG_DIGIT5;
                    4'd6:    nHex = SEG_DIGIT6;
                    4'd7:    nHex = SEG_DIGIT7;
                    4'd8:    nHex = SEG_DIGIT8;
                    4'd9:    nHex = SEG_DIGIT9;
                    default: nHex = SEG_BLANK;
                endcase
            end
            INPUT: begin
                // Coarse bar so the player cannot read the exact count
                if (tapCount <= 4'd4) begin
                    nHex = SEG_DASH;
                end else if (tapCount <= 4'd8) begin
                    nHex = SEG_DIGIT1;
                end else if (tapCount == 4'd9) begin
                    nHex = SEG_DIGIT2;
                end else begin
                    nHex = SEG_BLANK;           // Overshoot
                end
            end
            GOOD:     nHex = SEG_G;
            WRONG:    nHex = SEG_F;
            OUCH:     nHex = SEG_O;
            DRAW:     nHex = SEG_BLANK;         // Tie shows nothing
            WIN:      nHex = SEG_B;
            LOSE:     nHex = SEG_L;
            default:  nHex = SEG_BLANK;         // IDLE
        endcase
    end

endmodule

// File: rtl/gameCtrl.sv
`include "game_macros.svh"

module gameCtrl import gamePkg::*; (
    input  logic       CLK,
    input  logic       rstN,
    input  logic       startPress,
    input  logic       tapPress,
    input  digit_t     nextDigit,       // From the LFSR, sampled on QUESTION entry
    output gameState_t state,
    output digit_t     question,
    output digit_t     tapCount
);

    localparam int MaxWindow =
        (`INPUT_CYCLES > `QUESTION_CYCLES) ?
            ((`INPUT_CYCLES > `RESULT_CYCLES) ? `INPUT_CYCLES : `RESULT_CYCLES) :
            ((`QUESTION_CYCLES > `RESULT_CYCLES) ? `QUESTION_CYCLES : `RESULT_CYCLES);
    localparam int TimerW = $clog2(MaxWindow + 1);
    localparam int RoundW = $clog2(`ROUND_COUNT + 1);
    localparam logic [RoundW-1:0] RoundLast = RoundW'(`ROUND_COUNT);

    gameState_t        stateNext;
    logic [TimerW-1:0] timer;           // Cycles left in this phase
    logic [TimerW-1:0] windowLoad;      // Reload for the state being entered
    logic              timerDone;
    logic              entering;        // First cycle of a new state follows
    digit_t            tapNext;
    logic [RoundW-1:0] roundCnt;        // Rounds finished this match
    score_t            goodCnt;
    score_t            failCnt;         // WRONG plus OUCH

    assign timerDone = (timer == '0);
    assign entering  = (stateNext != state);
    assign tapNext   = (tapPress && tapCount != 4'hF) ? tapCount + 4'd1 : tapCount;  // Saturate

    always_comb begin
        stateNext = state;
        case (state)
            IDLE:     stateNext = READY;            // Leave reset state at once
            READY:    if (startPress) stateNext = QUESTION;
            QUESTION: begin
                if (tapPress) begin
                    stateNext = OUCH;               // Tapped too early
                end else if (timerDone) begin
                    stateNext = INPUT;
                end
            end
            INPUT:    if (timerDone) stateNext = (tapNext == question) ? GOOD : WRONG;
            GOOD, WRONG, OUCH: begin
                if (timerDone) begin
                    if (roundCnt < RoundLast) begin
                        stateNext = QUESTION;       // Next round
                    end else if (goodCnt > failCnt) begin
                        stateNext = WIN;
                    end else if (goodCnt < failCnt) begin
                        stateNext = LOSE;
                    end else begin
                        stateNext = DRAW;
                    end
                end
            end
            WIN, LOSE, DRAW: if (startPress) stateNext = READY;
            default:  stateNext = IDLE;
        endcase
    end

    always_comb begin
        case (stateNext)
            QUESTION:          windowLoad = TimerW'(`QUESTION_CYCLES - 1);
            INPUT:             windowLoad = TimerW'(`INPUT_CYCLES - 1);
            GOOD, WRONG, OUCH: windowLoad = TimerW'(`RESULT_CYCLES - 1);
            default:           windowLoad = '0;    // Untimed states
        endcase
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state    <= IDLE;
            timer    <= '0;
            question <= '0;
            tapCount <= '0;
            roundCnt <= '0;
            goodCnt  <= '0;
            failCnt  <= '0;
        end else begin
            state <= stateNext;

            if (entering) begin
                timer <= windowLoad;                // Reload on every entry
            end else if (!timerDone) begin
                timer <= timer - 1'b1;
            end

            if (entering && stateNext == QUESTION) begin
                question <= nextDigit;              // Fresh digit per round
                tapCount <= '0;
            end else if (state == INPUT) begin
                tapCount <= tapNext;
            end

            if (entering && isResult(stateNext)) begin
                roundCnt <= roundCnt + 1'b1;
                if (stateNext == GOOD) begin
                    goodCnt <= goodCnt + 3'd1;
                end else begin
                    failCnt <= failCnt + 3'd1;
                end
            end else if (entering && isFinal(state)) begin
                roundCnt <= '0;                     // New match from READY
                goodCnt  <= '0;
                failCnt  <= '0;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!rstN)
        state inside {IDLE, READY, QUESTION, INPUT, DRAW, WRONG, GOOD, OUCH, WIN, LOSE})
        else $error("gameCtrl: illegal state %b", state);

    // Verdict must come before the tally runs past the match length
    assert property (@(posedge CLK) disable iff (!rstN) roundCnt <= RoundLast)
        else $error("gameCtrl: round counter %0d past limit", roundCnt);

endmodule

// File: rtl/questionGen.sv
`include "game_macros.svh"

module questionGen import gamePkg::*; (
    input  logic   CLK,
    input  logic   rstN,
    output digit_t digit        // Always 0 to 9
);

    logic [15:0] lfsr;
    logic        feedback;
    logic [3:0]  lowBits;
    digit_t      folded;

    // Fibonacci form, taps 16 14 13 11, period 2^16 - 1
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    assign lowBits  = lfsr[3:0];
    assign folded   = (lowBits >= 4'd10) ? lowBits - 4'd10 : lowBits;  // 10..15 map to 0..5

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            lfsr  <= `LFSR_SEED;
            digit <= '0;
        end else begin
            lfsr  <= {lfsr[14:0], feedback};  // Advance every cycle
            digit <= folded;
        end
    end

    // The controller samples digit with no handshake, so it must be legal every cycle
    assert property (@(posedge CLK) disable iff (!rstN) digit <= 4'd9)
        else $error("questionGen: digit %0d out of range", digit);

endmodule

// File: rtl/btnSync.sv
`include "game_macros.svh"

module btnSync (
    input  logic CLK,
    input  logic rstN,
    input  logic raw,       // Asynchronous button level
    output logic press      // One cycle per accepted rising level
);

    localparam int CntW = $clog2(`DEBOUNCE_CYCLES + 1);
    localparam logic [CntW-1:0] CntLast = CntW'(`DEBOUNCE_CYCLES - 1);

    logic [1:0]      syncQ;         // Metastability chain
    logic            syncLevel;
    logic            stableLevel;   // Last accepted level
    logic [CntW-1:0] stableCnt;     // Cycles the new level has held

    assign syncLevel = syncQ[1];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            syncQ       <= '0;
            stableLevel <= 1'b0;
            stableCnt   <= '0;
            press       <= 1'b0;
        end else begin
            syncQ <= {syncQ[0], raw};
            press <= 1'b0;                          // Default no pulse
            if (syncLevel == stableLevel) begin
                stableCnt <= '0;                    // Bounce back, restart
            end else if (stableCnt == CntLast) begin
                stableLevel <= syncLevel;           // Level accepted
                stableCnt   <= '0;
                press       <= syncLevel;           // Pulse on rising only
            end else begin
                stableCnt <= stableCnt + 1'b1;
            end
        end
    end

    // A single accepted edge never yields a stretched pulse
    assert property (@(posedge CLK) disable iff (!rstN) press |=> !press)
        else $error("btnSync: press high two cycles in a row");

endmodule

// File: rtl/segPkg.sv
package segPkg;

    // Active low, bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] seg_t;

    localparam seg_t SEG_DIGIT0 = 7'b1000000;
    localparam seg_t SEG_DIGIT1 = 7'b1111001;
    localparam seg_t SEG_DIGIT2 = 7'b0100100;
    localparam seg_t SEG_DIGIT3 = 7'b0110000;
    localparam seg_t SEG_DIGIT4 = 7'b0011001;
    localparam seg_t SEG_DIGIT5 = 7'b0010010;
    localparam seg_t SEG_DIGIT6 = 7'b0000010;
    localparam seg_t SEG_DIGIT7 = 7'b1011000;   // Board style seven with the f bar
    localparam seg_t SEG_DIGIT8 = 7'b0000000;
    localparam seg_t SEG_DIGIT9 = 7'b0010000;

    localparam seg_t SEG_E     = 7'b0000110;    // Ready prompt
    localparam seg_t SEG_G     = 7'b1000010;    // Good
    localparam seg_t SEG_F     = 7'b0001110;    // Fail
    localparam seg_t SEG_O     = 7'b1000000;    // Ouch, same bits as zero
    localparam seg_t SEG_B     = 7'b0000011;    // Lower case b, beat
    localparam seg_t SEG_L     = 7'b1000111;    // Lose
    localparam seg_t SEG_DASH  = 7'b0111111;    // Only g lit
    localparam seg_t SEG_BLANK = 7'b1111111;    // All off

endpackage

// File: rtl/gamePkg.sv
package gamePkg;

    // Encodings match the board LED view of the state
    typedef enum logic [3:0] {
        IDLE     = 4'b0000,         // Reset only
        READY    = 4'b0010,         // Waiting for start
        QUESTION = 4'b0011,         // Digit on display
        INPUT    = 4'b0100,         // Tap window
        DRAW     = 4'b0110,         // Final, tie
        WRONG    = 4'b0111,         // Round result, count mismatch
        GOOD     = 4'b1000,         // Round result, count match
        OUCH     = 4'b1001,         // Round result, early tap
        WIN      = 4'b1010,         // Final, more goods
        LOSE     = 4'b1011          // Final, more failures
    } gameState_t;

    typedef logic [3:0] digit_t;    // Question digit or tap count
    typedef logic [2:0] score_t;    // Round tally

    function automatic logic isResult(gameState_t s);
        return (s == GOOD) || (s == WRONG) || (s == OUCH);
    endfunction

    function automatic logic isFinal(gameState_t s);
        return (s == WIN) || (s == LOSE) || (s == DRAW);
    endfunction

endpackage

// File: rtl/game_macros.svh
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

`define ROUND_COUNT      4          // Rounds per match
`define QUESTION_CYCLES  64         // Digit shown this long
`define INPUT_CYCLES     400        // Tap window
`define RESULT_CYCLES    32         // GOOD, WRONG or OUCH shown this long
`define DEBOUNCE_CYCLES  4          // Stable cycles before a level is accepted
`define LFSR_SEED        16'hACE1   // Any nonzero value

`endif
